//--- Makefile
# Verilator build and run of the systolic array testbench

VERILATOR ?= verilator
TOP       ?= tb_sya
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
verilog/sya_pkg.sv
verilog/sya_if.sv
verilog/sya_pe.sv
verilog/sya_fetch.sv
verilog/sya_pe_array.sv
verilog/sya_ofm_writer.sv
verilog/sya_top.sv
tests/tb_clk_gen.sv
tests/sya_props.sv
tests/tb_sya.sv

//--- tests/sya_props.sv
`timescale 1ns/100ps

module sya_props #(
    parameter int NUM_COL = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cfg_valid,
    input logic                 cfg_ready,
    input logic                 rd_addr_valid,
    input logic                 act_rd_addr_ready,
    input logic                 wgt_rd_addr_ready,
    input sya_pkg::addr_t       act_rd_addr,
    input sya_pkg::addr_t       wgt_rd_addr,
    input logic                 ofm_valid,
    input logic                 ofm_ready,
    input sya_pkg::addr_t       ofm_addr,
    input logic [NUM_COL*8-1:0] ofm_data
);

    // Address pair stays put until both sides take it
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr_valid && !(act_rd_addr_ready && wgt_rd_addr_ready)
        |=> rd_addr_valid && $stable(act_rd_addr) && $stable(wgt_rd_addr))
        else $error("read address pair dropped or changed before transfer");

    a_ofm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid && !ofm_ready |=> ofm_valid && $stable(ofm_addr) && $stable(ofm_data))
        else $error("output row dropped or changed before transfer");

    // Configuration closes as soon as a job is taken
    a_cfg_close: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_valid && cfg_ready |=> !cfg_ready)
        else $error("configuration ready stayed high after a transfer");

endmodule

bind sya_top sya_props #(.NUM_COL(NUM_COL)) u_props (
    .clk               (clk),
    .rst_n             (rst_n),
    .cfg_valid         (cfg_valid),
    .cfg_ready         (cfg_ready),
    .rd_addr_valid     (rd_addr_valid),
    .act_rd_addr_ready (act_rd_addr_ready),
    .wgt_rd_addr_ready (wgt_rd_addr_ready),
    .act_rd_addr       (act_rd_addr),
    .wgt_rd_addr       (wgt_rd_addr),
    .ofm_valid         (ofm_valid),
    .ofm_ready         (ofm_ready),
    .ofm_addr          (ofm_addr),
    .ofm_data          (ofm_data)
);

//--- tests/tb_clk_gen.sv
`timescale 1ns/100ps

// Free-running testbench clock
module tb_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end
endmodule

//--- tests/tb_sya.sv
`timescale 1ns/100ps

module tb_sya;
    import sya_pkg::*;

    localparam int NUM_ROW    = 4;
    localparam int NUM_COL    = 4;
    localparam int PERIOD     = 40;
    localparam int NUM_JOBS   = 10;
    localparam int CLEAN_JOBS = 4;
    localparam int MAX_CHN    = 20;
    localparam int MEM_DEPTH  = 512;
    // Worst case per job covers idle gap, stalled channels, flush, stalled rows and drain
    localparam int JOB_CYCLES = 4 + MAX_CHN * 16 + NUM_ROW + NUM_COL + NUM_ROW * 16 + 8;
    localparam int WD_CYCLES  = NUM_JOBS * JOB_CYCLES + 10;

    logic                 clk;
    logic                 rst_n;
    logic                 cfg_valid;
    logic                 cfg_ready;
    addr_t                cfg_act_base;
    addr_t                cfg_wgt_base;
    addr_t                cfg_ofm_base;
    chn_t                 cfg_chn;
    shift_t               cfg_shift;
    ofm_t                 cfg_zp;
    logic                 rd_addr_valid;
    addr_t                act_rd_addr;
    addr_t                wgt_rd_addr;
    logic                 act_rd_addr_ready;
    logic                 wgt_rd_addr_ready;
    logic [NUM_ROW*8-1:0] act_rd_data;
    logic                 act_rd_data_valid;
    logic [NUM_COL*8-1:0] wgt_rd_data;
    logic                 wgt_rd_data_valid;
    logic                 rd_data_ready;
    logic                 ofm_valid;
    logic                 ofm_ready;
    addr_t                ofm_addr;
    logic [NUM_COL*8-1:0] ofm_data;

    // Memory model and job state
    logic [31:0]          lfsr;
    logic [NUM_ROW*8-1:0] act_mem [MEM_DEPTH];
    logic [NUM_COL*8-1:0] wgt_mem [MEM_DEPTH];
    logic [NUM_COL*8-1:0] exp_row [NUM_ROW];
    addr_t                aq_act [$];
    addr_t                aq_wgt [$];
    addr_t                j_act;
    addr_t                j_wgt;
    addr_t                j_ofm;
    chn_t                 j_chn;
    shift_t               j_shift;
    ofm_t                 j_zp;
    int                   issued;
    int                   beats;
    int                   rows;
    int                   data_dly;
    bit                   data_on;
    bit                   cfg_pend;
    bit                   in_job;
    bit                   first_cyc;
    bit                   stall;

    tb_clk_gen #(.PERIOD(PERIOD)) u_clk_gen (.clk(clk));

    sya_top #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_dut (.*);

    // ================================================
    // Random source and checks
    // ================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_val(string name, logic [63:0] exp_v, logic [63:0] act_v);
        assert (exp_v === act_v) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            stop_run();
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("ERROR: %s", what);
            stop_run();
        end
    endtask

    // ================================================
    // Reference model
    // ================================================
    task automatic build_expect();
        psum_t sum;
        act_t  a;
        act_t  w;
        ofm_t  q;
        for (int r = 0; r < NUM_ROW; r++) begin
            for (int c = 0; c < NUM_COL; c++) begin
                sum = '0;
                for (int k = 0; k < int'(j_chn); k++) begin
                    a   = act_t'(act_mem[j_act + k][r*8 +: 8]);
                    w   = act_t'(wgt_mem[j_wgt + k][c*8 +: 8]);
                    sum = sum + a * w;
                end
                // Negative sums clamp to zero and the rest wraps mod 256
                if (sum < 0) q = 8'h00;
                else q = ofm_t'((sum >> j_shift) + j_zp);
                exp_row[r][c*8 +: 8] = q;
            end
        end
    endtask

    // One clock of driving at the falling edge and sampling what the next rising edge takes
    task automatic run_cycle();
        logic cfg_xfer;
        logic addr_xfer;
        logic data_xfer;
        logic ofm_xfer;
        @(negedge clk);
        cfg_valid = cfg_pend;
        if (cfg_pend) begin
            cfg_act_base = j_act;
            cfg_wgt_base = j_wgt;
            cfg_ofm_base = j_ofm;
            cfg_chn      = j_chn;
            cfg_shift    = j_shift;
            cfg_zp       = j_zp;
        end
        act_rd_addr_ready = !stall || (rand_bits(2) != 0);
        wgt_rd_addr_ready = !stall || (rand_bits(2) != 0);
        ofm_ready         = !stall || (rand_bits(2) != 0);
        // Memory answers in address order
        if (!data_on && aq_act.size() > 0) begin
            if (data_dly == 0) begin
                data_on     = 1'b1;
                act_rd_data = act_mem[aq_act[0]];
                wgt_rd_data = wgt_mem[aq_wgt[0]];
            end else begin
                data_dly--;
            end
        end
        act_rd_data_valid = data_on;
        wgt_rd_data_valid = data_on;
        #1;
        cfg_xfer  = cfg_valid && cfg_ready;
        addr_xfer = rd_addr_valid && act_rd_addr_ready && wgt_rd_addr_ready;
        data_xfer = data_on && rd_data_ready;
        ofm_xfer  = ofm_valid && ofm_ready;
        if (in_job && rows < NUM_ROW) check_true(!cfg_ready, "cfg_ready high during a job");
        if (first_cyc) check_true(rd_addr_valid, "no read address right after configuration");
        first_cyc = cfg_xfer;
        if (cfg_xfer) begin
            cfg_pend = 1'b0;
            in_job   = 1'b1;
        end
        if (addr_xfer) begin
            check_true(issued < int'(j_chn), "read address issued beyond the channel count");
            check_val("act read address", addr_t'(j_act + issued), act_rd_addr);
            check_val("wgt read address", addr_t'(j_wgt + issued), wgt_rd_addr);
            aq_act.push_back(act_rd_addr);
            aq_wgt.push_back(wgt_rd_addr);
            issued++;
        end
        if (data_xfer) begin
            void'(aq_act.pop_front());
            void'(aq_wgt.pop_front());
            data_on  = 1'b0;
            data_dly = stall ? int'(rand_bits(2)) : 0;
            beats++;
        end
        if (ofm_xfer) begin
            check_true(in_job && rows < NUM_ROW, "output write outside the expected rows");
            check_val("ofm address", addr_t'(j_ofm + rows), ofm_addr);
            check_val("ofm row data", exp_row[rows], ofm_data);
            rows++;
        end
    endtask

    // ================================================
    // Main sequence
    // ================================================
    initial begin : main
        lfsr              = 32'h49a7_7f8c;
        rst_n             = 1'b0;
        cfg_valid         = 1'b0;
        cfg_act_base      = '0;
        cfg_wgt_base      = '0;
        cfg_ofm_base      = '0;
        cfg_chn           = '0;
        cfg_shift         = '0;
        cfg_zp            = '0;
        act_rd_addr_ready = 1'b0;
        wgt_rd_addr_ready = 1'b0;
        act_rd_data       = '0;
        act_rd_data_valid = 1'b0;
        wgt_rd_data       = '0;
        wgt_rd_data_valid = 1'b0;
        ofm_ready         = 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            act_mem[i] = rand_bits(NUM_ROW * 8);
            wgt_mem[i] = rand_bits(NUM_COL * 8);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_true(cfg_ready && !rd_addr_valid && !rd_data_ready && !ofm_valid,
                   "outputs not idle after reset");

        for (int j = 0; j < NUM_JOBS; j++) begin
            // First jobs run stall-free and the rest under random back-pressure
            stall   = (j >= CLEAN_JOBS);
            j_chn   = chn_t'(1 + rand_bits(5) % MAX_CHN);
            j_act   = addr_t'(rand_bits(8));
            j_wgt   = addr_t'(rand_bits(8));
            j_ofm   = addr_t'(rand_bits(16));
            j_shift = shift_t'(rand_bits(5));
            j_zp    = ofm_t'(rand_bits(8));
            build_expect();
            repeat (stall ? int'(rand_bits(2)) : 0) run_cycle();
            issued   = 0;
            beats    = 0;
            rows     = 0;
            in_job   = 1'b0;
            cfg_pend = 1'b1;
            while (!(in_job && rows == NUM_ROW && cfg_ready)) run_cycle();
            in_job = 1'b0;
            check_val("address pairs per job", j_chn, issued);
            check_val("data beats per job", j_chn, beats);
        end

        $display("Everything OK");
        $finish;
    end

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run hung", WD_CYCLES);
        stop_run();
    end

endmodule

//--- verilog/sya_fetch.sv
`timescale 1ns/100ps

module sya_fetch #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Job configuration
    input  logic                              cfg_valid,
    output logic                              cfg_ready,
    input  sya_pkg::addr_t                    cfg_act_base,
    input  sya_pkg::addr_t                    cfg_wgt_base,
    input  sya_pkg::addr_t                    cfg_ofm_base,
    input  sya_pkg::chn_t                     cfg_chn,
    input  sya_pkg::shift_t                   cfg_shift,
    input  sya_pkg::ofm_t                     cfg_zp,
    output sya_pkg::addr_t                    ofm_base,
    output sya_pkg::shift_t                   shift,
    output sya_pkg::ofm_t                     zp,
    // Read address pair
    output logic                              rd_addr_valid,
    output sya_pkg::addr_t                    act_rd_addr,
    output sya_pkg::addr_t                    wgt_rd_addr,
    input  logic                              act_rd_addr_ready,
    input  logic                              wgt_rd_addr_ready,
    // Read data pair
    input  sya_pkg::act_t [NUM_ROW-1:0]       act_rd_data,
    input  logic                              act_rd_data_valid,
    input  sya_pkg::act_t [NUM_COL-1:0]       wgt_rd_data,
    input  logic                              wgt_rd_data_valid,
    output logic                              rd_data_ready,
    input  logic                              job_done,
    operand_if.source                         opd
);
    import sya_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;
    addr_t        act_base_q;
    addr_t        wgt_base_q;
    chn_t         chn_q;
    chn_t         issue_cnt;
    chn_t         beat_cnt;
    logic         cfg_take;
    logic         addr_take;
    logic         beat_take;
    logic         fetching;

    // ================================================
    // Job state machine
    // ================================================
    assign cfg_ready = (state == IDLE);
    assign cfg_take  = cfg_valid && cfg_ready;
    assign fetching  = (state == FETCH);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (cfg_take) state_nxt = FETCH;
            FETCH:    if (beat_take && opd.last) state_nxt = WAIT_OUT;
            WAIT_OUT: if (job_done) state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    // Configuration is held for the whole job
    always_ff @(posedge clk) begin
        if (cfg_take) begin
            act_base_q <= cfg_act_base;
            wgt_base_q <= cfg_wgt_base;
            ofm_base   <= cfg_ofm_base;
            chn_q      <= cfg_chn;
            shift      <= cfg_shift;
            zp         <= cfg_zp;
        end
    end

    // ================================================
    // Address issue and beat tagging
    // ================================================
    // One pair per channel, until all channels are out
    assign rd_addr_valid = fetching && (issue_cnt != chn_q);
    assign act_rd_addr   = act_base_q + issue_cnt;
    assign wgt_rd_addr   = wgt_base_q + issue_cnt;
    assign addr_take     = rd_addr_valid && act_rd_addr_ready && wgt_rd_addr_ready;

    // Data goes straight into the array, ready follows the array while fetching
    assign opd.valid     = fetching && act_rd_data_valid && wgt_rd_data_valid;
    assign opd.act       = act_rd_data;
    assign opd.wgt       = wgt_rd_data;
    assign opd.last      = (beat_cnt == chn_t'(chn_q - 1'b1));
    assign rd_data_ready = fetching && opd.ready;
    assign beat_take     = opd.valid && opd.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            issue_cnt <= '0;
            beat_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (cfg_take) begin
                issue_cnt <= '0;
                beat_cnt  <= '0;
            end else begin
                if (addr_take) issue_cnt <= issue_cnt + 1'b1;
                if (beat_take) beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/sya_if.sv
`timescale 1ns/100ps

// Operand beats from fetch into the array with one channel per beat
interface operand_if #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
);
    import sya_pkg::*;

    logic               valid;
    logic               ready;
    act_t [NUM_ROW-1:0] act;
    act_t [NUM_COL-1:0] wgt;
    // Final channel of the job
    logic               last;

    modport source (output valid, act, wgt, last, input ready);
    modport sink (input valid, act, wgt, last, output ready);

endinterface

// Finished result matrix from the array into the writer
interface psum_if #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
);
    import sya_pkg::*;

    logic                             valid;
    logic                             ready;
    psum_t [NUM_ROW-1:0][NUM_COL-1:0] psum;
    // Requantization settings of the job
    shift_t                           shift;
    ofm_t                             zp;

    modport source (output valid, psum, shift, zp, input ready);
    modport sink (input valid, psum, shift, zp, output ready);

endinterface

//--- verilog/sya_ofm_writer.sv
`timescale 1ns/100ps

module sya_ofm_writer #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  sya_pkg::addr_t               ofm_base,
    output logic                         ofm_valid,
    input  logic                         ofm_ready,
    output sya_pkg::addr_t               ofm_addr,
    output sya_pkg::ofm_t [NUM_COL-1:0]  ofm_data,
    output logic                         job_done,
    psum_if.sink                         res
);
    import sya_pkg::*;

    localparam int ROW_W = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1;

    logic                            busy;
    logic [ROW_W-1:0]                row_idx;
    addr_t                           addr_q;
    ofm_t [NUM_ROW-1:0][NUM_COL-1:0] row_buf;
    logic                            take;
    logic                            beat;

    // Clamp negatives, then shift, keep low byte and add zero point mod 256
    function automatic ofm_t requant(psum_t sum, shift_t sh, ofm_t zero_pt);
        psum_t shifted;
        shifted = sum >>> sh;
        if (sum[PSUM_WIDTH-1]) begin
            return '0;
        end
        return ofm_t'(shifted[7:0] + zero_pt);
    endfunction

    assign res.ready = !busy;
    assign take      = res.valid && res.ready;
    assign beat      = ofm_valid && ofm_ready;
    assign ofm_valid = busy;
    assign ofm_addr  = addr_q;
    assign ofm_data  = row_buf[row_idx];

    // ================================================
    // Requantized row buffer
    // ================================================
    always_ff @(posedge clk) begin
        if (take) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                for (int c = 0; c < NUM_COL; c++) begin
                    row_buf[r][c] <= requant(res.psum[r][c], res.shift, res.zp);
                end
            end
        end
    end

    // ================================================
    // Row writes
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            row_idx  <= '0;
            addr_q   <= '0;
            job_done <= 1'b0;
        end else begin
            job_done <= 1'b0;
            if (take) begin
                busy    <= 1'b1;
                row_idx <= '0;
                addr_q  <= ofm_base;
            end else if (beat) begin
                addr_q <= addr_q + 1'b1;
                if (row_idx == ROW_W'(NUM_ROW - 1)) begin
                    // Last row out, release the job
                    busy     <= 1'b0;
                    job_done <= 1'b1;
                end else begin
                    row_idx <= row_idx + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/sya_pe.sv
`timescale 1ns/100ps

// Output-stationary MAC cell that passes operands east and south
module sya_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            clear,
    input  sya_pkg::act_t   act_in,
    input  sya_pkg::act_t   wgt_in,
    output sya_pkg::act_t   act_out,
    output sya_pkg::act_t   wgt_out,
    output sya_pkg::psum_t  psum
);

    // Operand hand-off to the neighbors and accumulation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out <= '0;
            wgt_out <= '0;
            psum    <= '0;
        end else begin
            if (en) begin
                act_out <= act_in;
                wgt_out <= wgt_in;
            end
            if (clear) begin
                psum <= '0;
            end else if (en) begin
                psum <= psum + act_in * wgt_in;
            end
        end
    end

endmodule

//--- verilog/sya_pe_array.sv
`timescale 1ns/100ps

module sya_pe_array #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  sya_pkg::shift_t  shift_in,
    input  sya_pkg::ofm_t    zp_in,
    operand_if.sink          opd,
    psum_if.source           res
);
    import sya_pkg::*;

    // Lanes 0..NUM_ROW-1 are activations, the rest are weights
    localparam int LANES     = NUM_ROW + NUM_COL;
    localparam int FLUSH_LEN = NUM_ROW + NUM_COL - 1;
    localparam int FLUSH_W   = $clog2(FLUSH_LEN + 1);

    logic                             flushing;
    logic [FLUSH_W-1:0]               flush_cnt;
    logic                             res_valid;
    logic                             accept;
    logic                             take;
    logic                             step;
    act_t [LANES-1:0]                 feed;
    act_t [LANES-1:0]                 lane_out;
    act_t                             act_h [NUM_ROW][NUM_COL+1];
    act_t                             wgt_v [NUM_ROW+1][NUM_COL];
    psum_t [NUM_ROW-1:0][NUM_COL-1:0] psum_grid;

    assign opd.ready = !flushing && !res_valid;
    assign accept    = opd.valid && opd.ready;
    assign take      = res.valid && res.ready;
    assign step      = accept || flushing;
    // Zeros push the last channel through during flush
    assign feed      = flushing ? '0 : {opd.wgt, opd.act};

    // ================================================
    // Input skew
    // ================================================
    for (genvar i = 0; i < LANES; i++) begin : g_skew
        localparam int DLY = (i < NUM_ROW) ? i : i - NUM_ROW;
        if (DLY == 0) begin : g_direct
            assign lane_out[i] = feed[i];
        end else begin : g_delay
            act_t taps [DLY];
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    taps <= '{default: '0};
                end else if (step) begin
                    taps[0] <= feed[i];
                    for (int k = 1; k < DLY; k++) begin
                        taps[k] <= taps[k-1];
                    end
                end
            end
            assign lane_out[i] = taps[DLY-1];
        end
    end

    // ================================================
    // Cell grid
    // ================================================
    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        assign act_h[r][0] = lane_out[r];
    end
    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        assign wgt_v[0][c] = lane_out[NUM_ROW+c];
    end

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_pe_row
        for (genvar c = 0; c < NUM_COL; c++) begin : g_pe_col
            sya_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .en      (step),
                .clear   (take),
                .act_in  (act_h[r][c]),
                .wgt_in  (wgt_v[r][c]),
                .act_out (act_h[r][c+1]),
                .wgt_out (wgt_v[r+1][c]),
                .psum    (psum_grid[r][c])
            );
        end
    end

    // ================================================
    // Flush and result hand-off
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flushing  <= 1'b0;
            flush_cnt <= '0;
            res_valid <= 1'b0;
        end else begin
            if (accept && opd.last) begin
                flushing  <= 1'b1;
                flush_cnt <= '0;
            end else if (flushing) begin
                flush_cnt <= flush_cnt + 1'b1;
                if (flush_cnt == FLUSH_W'(FLUSH_LEN - 1)) begin
                    flushing  <= 1'b0;
                    res_valid <= 1'b1;
                end
            end
            if (take) res_valid <= 1'b0;
        end
    end

    // Grid is frozen while the result waits
    assign res.valid = res_valid;
    assign res.psum  = psum_grid;
    assign res.shift = shift_in;
    assign res.zp    = zp_in;

endmodule

//--- verilog/sya_pkg.sv
package sya_pkg;

    // ================================================
    // Widths
    // ================================================
    localparam int ACT_WIDTH   = 8;
    localparam int PSUM_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 16;
    localparam int CHN_WIDTH   = 16;
    localparam int SHIFT_WIDTH = 5;

    // ================================================
    // Data types
    // ================================================
    // Activation and weight elements share one type
    typedef logic signed [ACT_WIDTH-1:0]  act_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;
    // Unsigned requantized output element
    typedef logic [7:0]                   ofm_t;

    // Job configuration fields
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [CHN_WIDTH-1:0]   chn_t;
    typedef logic [SHIFT_WIDTH-1:0] shift_t;

    // Job sequencing in the fetch block
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WAIT_OUT
    } fetch_state_t;

endpackage

//--- verilog/sya_top.sv
`timescale 1ns/100ps

module sya_top #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Job configuration
    input  logic                          cfg_valid,
    output logic                          cfg_ready,
    input  sya_pkg::addr_t                cfg_act_base,
    input  sya_pkg::addr_t                cfg_wgt_base,
    input  sya_pkg::addr_t                cfg_ofm_base,
    input  sya_pkg::chn_t                 cfg_chn,
    input  sya_pkg::shift_t               cfg_shift,
    input  sya_pkg::ofm_t                 cfg_zp,
    // Operand reads
    output logic                          rd_addr_valid,
    output sya_pkg::addr_t                act_rd_addr,
    output sya_pkg::addr_t                wgt_rd_addr,
    input  logic                          act_rd_addr_ready,
    input  logic                          wgt_rd_addr_ready,
    input  sya_pkg::act_t [NUM_ROW-1:0]   act_rd_data,
    input  logic                          act_rd_data_valid,
    input  sya_pkg::act_t [NUM_COL-1:0]   wgt_rd_data,
    input  logic                          wgt_rd_data_valid,
    output logic                          rd_data_ready,
    // Output writes
    output logic                          ofm_valid,
    input  logic                          ofm_ready,
    output sya_pkg::addr_t                ofm_addr,
    output sya_pkg::ofm_t [NUM_COL-1:0]   ofm_data
);
    import sya_pkg::*;

    addr_t  ofm_base;
    shift_t shift;
    ofm_t   zp;
    logic   job_done;

    operand_if #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_opd_if ();
    psum_if    #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_psum_if ();

    sya_fetch #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg_valid         (cfg_valid),
        .cfg_ready         (cfg_ready),
        .cfg_act_base      (cfg_act_base),
        .cfg_wgt_base      (cfg_wgt_base),
        .cfg_ofm_base      (cfg_ofm_base),
        .cfg_chn           (cfg_chn),
        .cfg_shift         (cfg_shift),
        .cfg_zp            (cfg_zp),
        .ofm_base          (ofm_base),
        .shift             (shift),
        .zp                (zp),
        .rd_addr_valid     (rd_addr_valid),
        .act_rd_addr       (act_rd_addr),
        .wgt_rd_addr       (wgt_rd_addr),
        .act_rd_addr_ready (act_rd_addr_ready),
        .wgt_rd_addr_ready (wgt_rd_addr_ready),
        .act_rd_data       (act_rd_data),
        .act_rd_data_valid (act_rd_data_valid),
        .wgt_rd_data       (wgt_rd_data),
        .wgt_rd_data_valid (wgt_rd_data_valid),
        .rd_data_ready     (rd_data_ready),
        .job_done          (job_done),
        .opd               (u_opd_if.source)
    );

    sya_pe_array #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_pe_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift_in (shift),
        .zp_in    (zp),
        .opd      (u_opd_if.sink),
        .res      (u_psum_if.source)
    );

    sya_ofm_writer #(
        .NUM_ROW (NUM_ROW),
        .NUM_COL (NUM_COL)
    ) u_ofm_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .ofm_base  (ofm_base),
        .ofm_valid (ofm_valid),
        .ofm_ready (ofm_ready),
        .ofm_addr  (ofm_addr),
        .ofm_data  (ofm_data),
        .job_done  (job_done),
        .res       (u_psum_if.sink)
    );

endmodule
